/* hw/mips_pkg.sv */
/* Widths, MIPS encodings, ALU operations and the APB register map of the core.
   Imported by every RTL module and by the testbench. */
`default_nettype none

package mips_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;  // Register 0 reads as zero

    // Major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_OR,
        ALU_LUI
    } alu_op_t;

    // Memories
    localparam int    IMEM_WORDS     = 256;
    localparam int    DMEM_WORDS     = 256;
    localparam int    MEM_INDEX_BITS = 8;
    localparam word_t RESET_PC       = 32'h0000_0000;

    // APB map, byte addresses
    localparam logic [15:0] IMEM_BASE = 16'h0000;
    localparam logic [15:0] DMEM_BASE = 16'h1000;
    localparam logic [15:0] CTRL_ADDR = 16'h2000;

    localparam int CTRL_RUN_BIT  = 0;  // Written and read back
    localparam int STAT_HALT_BIT = 1;  // Read only

endpackage

`default_nettype wire

/* hw/word_memory.sv */
/* Word memory with one registered read port and one write port.
   Used as instruction memory and as data memory. */
`timescale 1ns/1ps
`default_nettype none

module word_memory import mips_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic                      clk,
    input  logic [MEM_INDEX_BITS-1:0] read_index,
    input  logic                      write_enable,
    input  logic [MEM_INDEX_BITS-1:0] write_index,
    input  word_t                     write_data,
    output word_t                     read_data
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_index] <= write_data;
        end
        read_data <= mem[read_index];  // Data one cycle after the index
    end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
/* Fetch stage: program counter, instruction memory and the fetch valid bit.
   The word for an address arrives one cycle after the address. */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run,
    input  logic                      stall,
    input  logic                      redirect,
    input  word_t                     redirect_pc,
    input  logic                      imem_write_enable,
    input  logic [MEM_INDEX_BITS-1:0] imem_write_index,
    input  word_t                     imem_write_data,
    output word_t                     fetch_pc,
    output word_t                     fetch_insn,
    output logic                      fetch_valid
);

    word_t pc;          // Next address to request
    word_t fetch_addr;  // Address presented to memory this cycle

    // On stall the held instruction is read again
    assign fetch_addr = stall ? fetch_pc : pc;

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            pc          <= RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= !redirect;  // Word in flight at redirect is dropped
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!stall) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        fetch_pc <= fetch_addr;  // Pairs with fetch_insn
    end

    word_memory #(.DEPTH(IMEM_WORDS)) imem_i (
        .clk          (clk),
        .read_index   (fetch_addr[MEM_INDEX_BITS+1:2]),
        .write_enable (imem_write_enable),
        .write_index  (imem_write_index),
        .write_data   (imem_write_data),
        .read_data    (fetch_insn)
    );

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
/* Decode stage: instruction decoder, register file, RAW interlock and the
   decode-to-execute register. Unknown opcodes leave a bubble. */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  word_t       fetch_pc,
    input  word_t       fetch_insn,
    input  logic        fetch_valid,
    input  logic        redirect,
    input  reg_addr_t   mem_dest,
    input  logic        mem_reg_write,
    input  reg_addr_t   wb_dest,
    input  word_t       wb_data,
    input  logic        wb_reg_write,
    output logic        stall,
    output logic        ex_valid,
    output word_t       ex_pc,
    output word_t       ex_a,
    output word_t       ex_b,
    output word_t       ex_imm,
    output logic [4:0]  ex_shamt,
    output alu_op_t     ex_alu_op,
    output logic        ex_op2_imm,
    output logic        ex_is_branch,
    output logic        ex_branch_ne,
    output logic        ex_is_jump,
    output logic [25:0] ex_jump_target,
    output logic        ex_mem_read,
    output logic        ex_mem_write,
    output logic        ex_reg_write,
    output reg_addr_t   ex_dest
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  dest;
    logic       d_known;
    alu_op_t    d_alu_op;
    logic       d_op2_imm;
    logic       d_zero_ext;   // ORI only
    logic       d_is_branch;
    logic       d_is_jump;
    logic       d_mem_read;
    logic       d_mem_write;
    logic       d_writes;
    logic       d_dest_rt;    // I-type writes rt, R-type rd
    logic       uses_rs;
    logic       uses_rt;
    logic       hazard;
    logic       issue;
    word_t      regs [32];
    word_t      rs_val;
    word_t      rt_val;

    assign opcode = fetch_insn[31:26];
    assign funct  = fetch_insn[5:0];
    assign rs     = fetch_insn[25:21];
    assign rt     = fetch_insn[20:16];
    assign dest   = d_dest_rt ? rt : fetch_insn[15:11];

    always_comb begin
        d_known     = 1'b1;
        d_alu_op    = ALU_ADD;
        d_op2_imm   = 1'b1;
        d_zero_ext  = 1'b0;
        d_is_branch = 1'b0;
        d_is_jump   = 1'b0;
        d_mem_read  = 1'b0;
        d_mem_write = 1'b0;
        d_writes    = 1'b0;
        d_dest_rt   = 1'b1;
        uses_rs     = 1'b1;
        uses_rt     = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                d_op2_imm = 1'b0;
                d_writes  = 1'b1;
                d_dest_rt = 1'b0;
                uses_rt   = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: d_alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: d_alu_op = ALU_SUB;
                    FN_SLT:          d_alu_op = ALU_SLT;
                    FN_SLL: begin
                        d_alu_op = ALU_SLL;
                        uses_rs  = 1'b0;  // Shifts read rt only
                    end
                    FN_SRL: begin
                        d_alu_op = ALU_SRL;
                        uses_rs  = 1'b0;
                    end
                    default: d_known = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU: d_writes = 1'b1;
            OP_ORI: begin
                d_alu_op   = ALU_OR;
                d_zero_ext = 1'b1;
                d_writes   = 1'b1;
            end
            OP_LUI: begin
                d_alu_op = ALU_LUI;
                d_writes = 1'b1;
                uses_rs  = 1'b0;
            end
            OP_LW: begin
                d_mem_read = 1'b1;  // Address is rs plus offset
                d_writes   = 1'b1;
            end
            OP_SW: begin
                d_mem_write = 1'b1;
                uses_rt     = 1'b1;  // Store data
            end
            OP_BEQ, OP_BNE: begin
                d_alu_op    = ALU_SUB;  // Zero difference means equal
                d_op2_imm   = 1'b0;
                d_is_branch = 1'b1;
                uses_rt     = 1'b1;
            end
            OP_J: begin
                d_is_jump = 1'b1;
                uses_rs   = 1'b0;
            end
            default: d_known = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Register file, written in write-back

    // Read sees the value written this cycle
    assign rs_val = (rs == '0) ? '0 : (wb_reg_write && wb_dest == rs) ? wb_data : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (wb_reg_write && wb_dest == rt) ? wb_data : regs[rt];

    always_ff @(posedge clk) begin
        if (wb_reg_write && wb_dest != '0) begin
            regs[wb_dest] <= wb_data;
        end
    end

    //////////////////////////////////////////////////
    // Interlock and execute register

    // Writers in execute or memory; write-back is covered by the bypass above
    assign hazard = (ex_reg_write && ((uses_rs && rs == ex_dest) || (uses_rt && rt == ex_dest)))
        || (mem_reg_write && ((uses_rs && rs == mem_dest) || (uses_rt && rt == mem_dest)));
    assign stall = fetch_valid && d_known && !redirect && hazard;
    assign issue = fetch_valid && d_known && !redirect && !hazard;

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            ex_valid     <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_is_jump   <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_valid     <= issue;  // Bubble on stall or squash
            ex_is_branch <= issue && d_is_branch;
            ex_is_jump   <= issue && d_is_jump;
            ex_mem_read  <= issue && d_mem_read;
            ex_mem_write <= issue && d_mem_write;
            ex_reg_write <= issue && d_writes && dest != '0;  // r0 never written
        end
    end

    always_ff @(posedge clk) begin
        ex_pc          <= fetch_pc;
        ex_a           <= rs_val;
        ex_b           <= rt_val;
        ex_imm         <= d_zero_ext ? {16'b0, fetch_insn[15:0]}
                                     : {{16{fetch_insn[15]}}, fetch_insn[15:0]};
        ex_shamt       <= fetch_insn[10:6];
        ex_alu_op      <= d_alu_op;
        ex_op2_imm     <= d_op2_imm;
        ex_branch_ne   <= (opcode == OP_BNE);
        ex_jump_target <= fetch_insn[25:0];
        ex_dest        <= dest;
    end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
/* Execute stage: ALU, branch and jump resolution, halt detection and the
   execute-to-memory register. Redirect is combinational from this stage. */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic        ex_valid,
    input  word_t       ex_pc,
    input  word_t       ex_a,
    input  word_t       ex_b,
    input  word_t       ex_imm,
    input  logic [4:0]  ex_shamt,
    input  alu_op_t     ex_alu_op,
    input  logic        ex_op2_imm,
    input  logic        ex_is_branch,
    input  logic        ex_branch_ne,
    input  logic        ex_is_jump,
    input  logic [25:0] ex_jump_target,
    input  logic        ex_mem_read,
    input  logic        ex_mem_write,
    input  logic        ex_reg_write,
    input  reg_addr_t   ex_dest,
    output logic        redirect,
    output word_t       redirect_pc,
    output logic        halt,
    output logic        mem_valid,
    output word_t       mem_result,
    output word_t       mem_store_data,
    output logic        mem_read,
    output logic        mem_write,
    output logic        mem_reg_write,
    output reg_addr_t   mem_dest
);

    word_t op2;
    word_t alu_result;
    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    logic  taken;

    assign op2 = ex_op2_imm ? ex_imm : ex_b;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_result = ex_a + op2;
            ALU_SUB: alu_result = ex_a - op2;
            ALU_SLT: alu_result = word_t'($signed(ex_a) < $signed(op2));
            ALU_SLL: alu_result = op2 << ex_shamt;
            ALU_SRL: alu_result = op2 >> ex_shamt;  // Logical
            ALU_OR:  alu_result = ex_a | op2;
            ALU_LUI: alu_result = {op2[15:0], 16'b0};
            default: alu_result = '0;
        endcase
    end

    // Targets relative to the delay-slot address, no slot executed
    assign pc_plus4      = ex_pc + 32'd4;
    assign branch_target = pc_plus4 + {ex_imm[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], ex_jump_target, 2'b00};

    assign taken       = ex_is_branch && ((alu_result == '0) != ex_branch_ne);
    assign redirect    = taken || ex_is_jump;  // Squashes decode and fetch
    assign redirect_pc = ex_is_jump ? jump_target : branch_target;
    assign halt        = ex_is_jump && (jump_target == ex_pc);  // Self-jump

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            mem_valid     <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_reg_write <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
            mem_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= alu_result;  // Also the load/store address
        mem_store_data <= ex_b;
        mem_dest       <= ex_dest;
    end

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
/* Memory and write-back: data memory shared with APB while idle, the
   memory-to-writeback register and the write-back data select. */
`timescale 1ns/1ps
`default_nettype none

module memory_stage import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run,
    input  logic                      mem_valid,
    input  word_t                     mem_result,
    input  word_t                     mem_store_data,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic                      mem_reg_write,
    input  reg_addr_t                 mem_dest,
    input  logic [MEM_INDEX_BITS-1:0] apb_dmem_index,
    input  logic                      apb_dmem_write,
    input  word_t                     apb_wdata,
    output word_t                     dmem_read_data,
    output reg_addr_t                 wb_dest,
    output word_t                     wb_data,
    output logic                      wb_reg_write
);

    logic [MEM_INDEX_BITS-1:0] dmem_index;
    logic                      dmem_write;
    word_t                     dmem_wdata;
    word_t                     wb_result;
    logic                      wb_load;  // Take memory data in write-back

    // Core owns the ports while running, APB while idle
    assign dmem_index = run ? mem_result[MEM_INDEX_BITS+1:2] : apb_dmem_index;
    assign dmem_write = run ? (mem_valid && mem_write) : apb_dmem_write;
    assign dmem_wdata = run ? mem_store_data : apb_wdata;

    word_memory #(.DEPTH(DMEM_WORDS)) dmem_i (
        .clk          (clk),
        .read_index   (dmem_index),
        .write_enable (dmem_write),
        .write_index  (dmem_index),
        .write_data   (dmem_wdata),
        .read_data    (dmem_read_data)
    );

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= mem_valid && mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest   <= mem_dest;
        wb_result <= mem_result;
        wb_load   <= mem_read;
    end

    // Load data lands one cycle after its address
    assign wb_data = wb_load ? dmem_read_data : wb_result;

endmodule

`default_nettype wire

/* hw/apb_control.sv */
/* APB slave of the core: memory loading while idle, the run control word and
   the halted status. Every access has one wait state. */
`timescale 1ns/1ps
`default_nettype none

module apb_control import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [15:0]               paddr,
    input  word_t                     pwdata,
    input  logic                      halt,
    input  word_t                     dmem_read_data,
    output word_t                     prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      run,
    output logic                      imem_write_enable,
    output logic [MEM_INDEX_BITS-1:0] imem_write_index,
    output logic [MEM_INDEX_BITS-1:0] apb_dmem_index,
    output logic                      apb_dmem_write
);

    logic  waited;  // First access cycle seen
    logic  halted;
    logic  hit_imem;
    logic  hit_dmem;
    logic  hit_ctrl;
    logic  allowed;
    logic  ctrl_write;
    word_t status;

    // Each memory region spans its word index plus the byte offset
    assign hit_imem = paddr[15:MEM_INDEX_BITS+2] == IMEM_BASE[15:MEM_INDEX_BITS+2];
    assign hit_dmem = paddr[15:MEM_INDEX_BITS+2] == DMEM_BASE[15:MEM_INDEX_BITS+2];
    assign hit_ctrl = paddr == CTRL_ADDR;

    // Memories only while idle, instruction memory write-only
    assign allowed = hit_ctrl || (!run && (hit_dmem || (hit_imem && pwrite)));

    assign pready     = psel && penable && waited;  // Second access cycle
    assign pslverr    = pready && !allowed;
    assign ctrl_write = pready && pwrite && hit_ctrl;

    assign imem_write_enable = pready && pwrite && hit_imem && !run;
    assign apb_dmem_write    = pready && pwrite && hit_dmem && !run;
    assign imem_write_index  = paddr[MEM_INDEX_BITS+1:2];
    assign apb_dmem_index    = paddr[MEM_INDEX_BITS+1:2];  // Read data ready by pready

    always_comb begin
        status                = '0;
        status[CTRL_RUN_BIT]  = run;
        status[STAT_HALT_BIT] = halted;
    end

    assign prdata = hit_ctrl ? status : dmem_read_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            waited <= 1'b0;
            run    <= 1'b0;
            halted <= 1'b0;
        end else begin
            waited <= psel && penable && !waited;
            if (ctrl_write) begin
                run <= pwdata[CTRL_RUN_BIT];
            end
            // Stopping wins over a halt pulse in the same cycle
            // Pipeline registers lag the stop by a cycle, so a stopped core sets nothing
            if (ctrl_write && !pwdata[CTRL_RUN_BIT]) begin
                halted <= 1'b0;
            end else if (halt && run) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mips_core.sv */
/* Top level of the five-stage core behind its APB slave port.
   Port names of the stages match the nets below, so instances connect by name. */
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  word_t       pwdata,
    output word_t       prdata,
    output logic        pready,
    output logic        pslverr
);

    // APB control
    logic                      run;
    logic                      halt;
    logic                      imem_write_enable;
    logic [MEM_INDEX_BITS-1:0] imem_write_index;
    logic [MEM_INDEX_BITS-1:0] apb_dmem_index;
    logic                      apb_dmem_write;
    word_t                     dmem_read_data;

    // Fetch to decode, and feedback
    logic  stall;
    logic  redirect;
    word_t redirect_pc;
    word_t fetch_pc;
    word_t fetch_insn;
    logic  fetch_valid;

    // Execute input register
    logic        ex_valid;
    word_t       ex_pc;
    word_t       ex_a;
    word_t       ex_b;
    word_t       ex_imm;
    logic [4:0]  ex_shamt;
    alu_op_t     ex_alu_op;
    logic        ex_op2_imm;
    logic        ex_is_branch;
    logic        ex_branch_ne;
    logic        ex_is_jump;
    logic [25:0] ex_jump_target;
    logic        ex_mem_read;
    logic        ex_mem_write;
    logic        ex_reg_write;
    reg_addr_t   ex_dest;

    // Memory input register
    logic      mem_valid;
    word_t     mem_result;
    word_t     mem_store_data;
    logic      mem_read;
    logic      mem_write;
    logic      mem_reg_write;
    reg_addr_t mem_dest;

    // Write-back
    reg_addr_t wb_dest;
    word_t     wb_data;
    logic      wb_reg_write;

    apb_control apb_control_i (.*);

    fetch_stage fetch_stage_i (
        .imem_write_data (pwdata),
        .*
    );

    decode_stage decode_stage_i (.*);

    execute_stage execute_stage_i (.*);

    memory_stage memory_stage_i (
        .apb_wdata (pwdata),
        .*
    );

endmodule

`default_nettype wire

/* sim/apb_control_properties.sv */
/* Concurrent checks of the APB slave handshake and the run flag.
   Bound to every apb_control instance. */
`timescale 1ns/1ps
`default_nettype none

module apb_control_properties import mips_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [15:0] paddr,
    input logic        pready,
    input logic        pslverr,
    input logic        run
);

    // Ready only in an access phase that already waited a cycle
    pready_in_access: assert property (@(posedge clk) disable iff (reset)
        pready |-> psel && penable && $past(psel && penable && !pready))
        else $error("pready high outside the access phase");

    // Refusals only with ready, never on the control word
    pslverr_with_ready: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> pready && paddr != CTRL_ADDR)
        else $error("pslverr high without pready or on the control word");

    // One wait state, then ready
    one_wait_state: assert property (@(posedge clk) disable iff (reset)
        psel && $rose(penable) |-> !pready ##1 pready)
        else $error("pready not in the second access cycle");

    // Low out of reset, raised only by a control write
    run_low_after_reset: assert property (@(posedge clk)
        reset || (!run && !(pready && pwrite && paddr == CTRL_ADDR)) |=> !run)
        else $error("run high without a control write");

endmodule

bind apb_control apb_control_properties apb_control_properties_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pready  (pready),
    .pslverr (pslverr),
    .run     (run)
);

`default_nettype wire

/* sim/mips_core_tb.sv */
/* Testbench of the core. Replays the stimulus records over APB, runs each
   loaded program to its halt and checks memory and register read-back. */
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb import mips_pkg::*; ();

    // Record commands, three words each: command, address, data
    localparam word_t CMD_END       = 32'h0;
    localparam word_t CMD_WRITE     = 32'h1;
    localparam word_t CMD_WRITE_ERR = 32'h2;  // Write that must get pslverr
    localparam word_t CMD_READ      = 32'h3;
    localparam word_t CMD_READ_ERR  = 32'h4;
    localparam word_t CMD_RUN       = 32'h5;
    localparam word_t CMD_TEST_END  = 32'h6;

    localparam int STIM_WORDS = 1024;
    localparam int POLL_LIMIT = 80;   // Status reads before giving up on halt

    logic        clk = 1'b0;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        pslverr;

    word_t stim [STIM_WORDS];
    int    errors;
    int    checks;
    int    tests;
    int    test_errors;
    int    cycles;
    int    cycle_limit = 1000000;  // Replaced once the records are counted

    always #5 clk = ~clk;  // 10 ns period

    mips_core mips_core_i (.*);

    //////////////////////////////////////////////////
    // Timeout

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, stimulus did not complete", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // APB master and checks

    // Called on a falling edge, returns on a falling edge
    task automatic apb_transfer(input logic write, input logic [15:0] addr, input word_t data,
                                output word_t rdata, output logic err);
        int waits;
        waits   = 0;
        psel    = 1'b1;  // Setup cycle
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);   // Second access cycle
        while (!pready && waits < 4) begin
            waits++;
            @(negedge clk);
        end
        checks++;
        assert (pready && waits == 0) else begin
            $display("APB transfer to %h missed the second access cycle", addr);
            errors++;
            test_errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);   // Transfer completed on the rising edge
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_word(input string name, input logic [15:0] addr,
                              input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s at %h: got %h expected %h", name, addr, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Start the core, wait for the halted bit, stop it again
    task automatic run_program();
        word_t rdata;
        logic  err;
        int    polls;
        apb_transfer(1'b1, CTRL_ADDR, 32'h1, rdata, err);
        check_word("pslverr", CTRL_ADDR, {31'b0, err}, 32'h0);
        polls = 0;
        rdata = '0;
        while (!rdata[STAT_HALT_BIT] && polls < POLL_LIMIT) begin
            apb_transfer(1'b0, CTRL_ADDR, '0, rdata, err);
            check_word("pslverr", CTRL_ADDR, {31'b0, err}, 32'h0);
            polls++;
        end
        checks++;
        assert (rdata[STAT_HALT_BIT]) else begin
            $display("Core did not halt within %0d status polls", POLL_LIMIT);
            errors++;
            test_errors++;
        end
        apb_transfer(1'b1, CTRL_ADDR, '0, rdata, err);  // Stop, clears halted
        check_word("pslverr", CTRL_ADDR, {31'b0, err}, 32'h0);
    endtask

    //////////////////////////////////////////////////
    // Stimulus interpreter

    initial begin
        int    idx;
        int    records;
        int    runs;
        word_t cmd;
        word_t addr;
        word_t data;
        word_t rdata;
        logic  err;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        $readmemh("sim/mips_core_stimulus.hex", stim);

        // Limit from the record count
        idx     = 0;
        records = 0;
        runs    = 0;
        while (idx <= STIM_WORDS - 3 && stim[idx] != CMD_END) begin
            if (stim[idx] == CMD_RUN) begin
                runs++;
            end
            records++;
            idx += 3;
        end
        cycle_limit = records * 10 + runs * 400 + 8;  // Plus reset
        if (records == 0) begin
            $display("Stimulus file holds no records");
            errors++;
        end

        repeat (8) @(negedge clk);
        reset = 1'b0;

        idx = 0;
        while (idx <= STIM_WORDS - 3 && stim[idx] != CMD_END) begin
            cmd  = stim[idx];
            addr = stim[idx + 1];
            data = stim[idx + 2];
            case (cmd)
                CMD_WRITE, CMD_WRITE_ERR: begin
                    apb_transfer(1'b1, addr[15:0], data, rdata, err);
                    check_word("pslverr", addr[15:0], {31'b0, err},
                               (cmd == CMD_WRITE_ERR) ? 32'h1 : 32'h0);
                end
                CMD_READ: begin
                    apb_transfer(1'b0, addr[15:0], '0, rdata, err);
                    check_word("pslverr", addr[15:0], {31'b0, err}, 32'h0);
                    check_word("prdata", addr[15:0], rdata, data);
                end
                CMD_READ_ERR: begin
                    apb_transfer(1'b0, addr[15:0], '0, rdata, err);
                    check_word("pslverr", addr[15:0], {31'b0, err}, 32'h1);
                end
                CMD_RUN: run_program();
                CMD_TEST_END: begin
                    tests++;
                    $display("Test %0d %s with %0d errors", addr,
                             (test_errors == 0) ? "passed" : "failed", test_errors);
                    test_errors = 0;
                end
                default: begin
                    $display("Unknown stimulus command %h at record %0d", cmd, idx / 3);
                    errors++;
                end
            endcase
            idx += 3;
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/mips_core_stimulus.hex */
// Columns: command address data, all hex
// 1 write, 2 refused write, 3 read and compare, 4 refused read, 5 run to halt, 6 end of test, 0 end
// Test 1: register map
3 2000 00000000 // Status after reset
1 0000 1000ffff // BEQ r0,r0 to itself, spins without halt
1 2000 00000001
3 2000 00000001
2 0004 00000000 // Memories locked while running
4 1000 00000000
2 1000 12345678
1 2000 00000000
3 2000 00000000
4 0000 00000000 // Imem is write-only
4 3000 00000000 // Unmapped
2 3000 00000000
6 0001 00000000
// Test 2: dependent arithmetic chain
1 0000 20010005 // addi r1,r0,5
1 0004 2022fffd // addi r2,r1,-3
1 0008 00221820 // add r3,r1,r2
1 000c 00432022 // sub r4,r2,r3
1 0010 34658000 // ori r5,r3,0x8000
1 0014 3c061234 // lui r6,0x1234
1 0018 0081382a // slt r7,r4,r1
1 001c 00074100 // sll r8,r7,4
1 0020 00064a02 // srl r9,r6,8
1 0024 ac020000 // sw r2..r9 to 0x00..0x1c
1 0028 ac030004
1 002c ac040008
1 0030 ac05000c
1 0034 ac060010
1 0038 ac070014
1 003c ac080018
1 0040 ac09001c
1 0044 08000011 // j self
5 0000 00000000
3 1000 00000002
3 1004 00000007
3 1008 fffffffb
3 100c 00008007
3 1010 12340000
3 1014 00000001
3 1018 00000010
3 101c 00123400
6 0002 00000000
// Test 3: loads and stores
1 1080 11111111
1 1084 22220000
1 0000 8c010080 // lw r1,0x80(r0)
1 0004 8c020084 // lw r2,0x84(r0)
1 0008 00221820 // add r3,r1,r2
1 000c 20040040 // addi r4,r0,0x40
1 0010 ac830050 // sw r3,0x50(r4)
1 0014 00412822 // sub r5,r2,r1
1 0018 ac850054 // sw r5,0x54(r4)
1 001c 8c860050 // lw r6,0x50(r4)
1 0020 ac860058 // sw r6,0x58(r4)
1 0024 08000009 // j self
5 0000 00000000
3 1080 11111111
3 1090 33331111
3 1094 1110eeef
3 1098 33331111
6 0003 00000000
// Test 4: branches and jump, skipped markers stay zero
1 10a8 00000000
1 10ac 00000000
1 10b8 00000000
1 10bc 00000000
1 10c0 00000000
1 10c4 00000000
1 0000 20010001 // addi r1,r0,1
1 0004 20020002 // addi r2,r0,2
1 0008 20030055 // addi r3,r0,0x55
1 000c 10220002 // beq r1,r2 not taken
1 0010 ac0300a0
1 0014 ac0300a4
1 0018 10210002 // beq r1,r1 taken to 0x24
1 001c ac0300a8
1 0020 ac0300ac
1 0024 14210002 // bne r1,r1 not taken
1 0028 ac0300b0
1 002c ac0300b4
1 0030 14220002 // bne r1,r2 taken to 0x3c
1 0034 ac0300b8
1 0038 ac0300bc
1 003c 08000012 // j 0x48
1 0040 ac0300c0
1 0044 ac0300c4
1 0048 ac0300c8
1 004c 08000013 // j self
5 0000 00000000
3 10a0 00000055
3 10a4 00000055
3 10a8 00000000
3 10ac 00000000
3 10b0 00000055
3 10b4 00000055
3 10b8 00000000
3 10bc 00000000
3 10c0 00000000
3 10c4 00000000
3 10c8 00000055
6 0004 00000000
// Test 5: halt, stop and a second run of a changed program
1 0000 20010077 // addi r1,r0,0x77
1 0004 ac0100d0 // sw r1,0xd0(r0)
1 0008 08000002 // j self
5 0000 00000000
3 2000 00000000 // Halted cleared by stop
3 10d0 00000077
1 0000 20010099 // addi r1,r0,0x99
5 0000 00000000
3 10d0 00000099
3 2000 00000000
6 0005 00000000
0 0000 00000000

/* filelist.f */
hw/mips_pkg.sv
hw/word_memory.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/apb_control.sv
hw/mips_core.sv
sim/apb_control_properties.sv
sim/mips_core_tb.sv

/* Makefile */
# Verilator build and run of the core testbench

TOP = mips_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log
